// File: src/float_pkg.sv
package float_pkg;

    ////////////////////
    // Single-precision word layout
    ////////////////////

    // Whole word
    localparam int float_width = 32;

    // Biased exponent field
    localparam int exp_width = 8;

    // Stored fraction, hidden one not included
    localparam int mnt_width = 23;

    // Fraction with the hidden one put back in front
    localparam int full_mnt_width = mnt_width + 1;

    // Exponent bias of the format
    localparam int exp_bias = 127;

    // Field view of one word, sign on top
    typedef struct packed {
        logic                 sign;
        logic [exp_width-1:0] exponent;
        logic [mnt_width-1:0] mantissa;
    } float_fields_t;

    // Same 32 bits read either as a raw word or as fields
    typedef union packed {
        logic [float_width-1:0] raw;
        float_fields_t          fields;
    } float_word_t;

endpackage

// File: src/cosine_pkg.sv
package cosine_pkg;

    import float_pkg::*;

    ////////////////////
    // Series constants
    ////////////////////

    // Leading term of the series
    localparam float_word_t float_one = 32'h3F80_0000;

    // Stands in for the division by 2
    localparam float_word_t float_half = 32'h3F00_0000;

    // 1/24 rounded to nearest, stands in for the division by 24
    localparam float_word_t float_inv_24 = 32'h3D2A_AAAB;

    ////////////////////
    // Sequencer steps
    ////////////////////

    // First four steps use the multiplier, last two the adder
    typedef enum logic [2:0] {
        idle,
        square,
        fourth,
        half_term,
        quarter_term,
        subtract,
        sum
    } cosine_step_t;

endpackage

// File: src/float_op_if.sv
`timescale 1ns/100ps

interface float_op_if
    import float_pkg::*;
();

    // One-cycle request strobe
    logic        start;

    // Held by the requester from start until done
    float_word_t operand_a;
    float_word_t operand_b;

    // Valid with done, then held until the next start
    float_word_t result;
    logic        done;

    modport requester (output start, operand_a, operand_b, input result, done);

    modport unit (input start, operand_a, operand_b, output result, done);

endinterface

// File: src/float_multiplier.sv
`timescale 1ns/100ps

module float_multiplier
    import float_pkg::*;
(
    input  logic     clock,
    input  logic     i_reset,
    float_op_if.unit op
);

    // Bias minus the one gained by the product's top half
    localparam logic [exp_width-1:0] exp_offset = exp_width'(exp_bias - 1);

    // Stage counter, zero when idle
    logic [1:0]                    stage;

    logic                          sign_r;
    logic                          zero_r;
    logic [exp_width-1:0]          exp_r;
    logic [full_mnt_width-1:0]     mnt_a;
    logic [full_mnt_width-1:0]     mnt_b;
    logic [full_mnt_width-1:0]     mnt_r;
    logic [2*full_mnt_width-1:0]   product;
    float_word_t                   packed_word;

    // Full 48-bit mantissa product
    assign product = mnt_a * mnt_b;

    // Output word, forced to zero by the operand check
    always_comb
    begin
        packed_word.raw = '0;
        if (!zero_r)
        begin
            packed_word.fields.sign     = sign_r;
            packed_word.fields.exponent = exp_r;
            packed_word.fields.mantissa = mnt_r[mnt_width-1:0];
        end
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (i_reset)
        begin
            stage   <= 2'd0;
            op.done <= 1'b0;
        end
        else
        begin
            op.done <= 1'b0;
            if (stage == 2'd0)
            begin
                if (op.start)
                    stage <= 2'd1;
            end
            else if (stage == 2'd3)
            begin
                // Pack stage, result goes out with done
                stage   <= 2'd0;
                op.done <= 1'b1;
            end
            else
                stage <= stage + 2'd1;
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (stage == 2'd0 && op.start)
        begin
            // Split fields, put the hidden ones back
            mnt_a  <= {1'b1, op.operand_a.fields.mantissa};
            mnt_b  <= {1'b1, op.operand_b.fields.mantissa};
            sign_r <= op.operand_a.fields.sign ^ op.operand_b.fields.sign;
            // Exponent wraps, no overflow handling
            exp_r  <= op.operand_a.fields.exponent + op.operand_b.fields.exponent - exp_offset;
            // Zero when exponent and mantissa are both clear
            zero_r <= ({op.operand_a.fields.exponent, op.operand_a.fields.mantissa} == '0) ||
                      ({op.operand_b.fields.exponent, op.operand_b.fields.mantissa} == '0);
        end

        // Top half of the product, low bits dropped
        if (stage == 2'd1)
            mnt_r <= product[2*full_mnt_width-1:full_mnt_width];

        // Both inputs carry a hidden one, so the top half
        // is off by at most one position
        if (stage == 2'd2 && !mnt_r[full_mnt_width-1])
        begin
            mnt_r <= mnt_r << 1;
            exp_r <= exp_r - 1'b1;
        end

        if (stage == 2'd3)
            op.result <= packed_word;
    end

endmodule

// File: src/float_adder.sv
`timescale 1ns/100ps

module float_adder
    import float_pkg::*;
(
    input  logic     clock,
    input  logic     i_reset,
    float_op_if.unit op
);

    // Stage counter, zero when idle
    logic [1:0]                stage;

    // Operand ordering, seen only on the start cycle
    float_word_t               large_w;
    float_word_t               small_w;
    logic                      a_is_larger;
    logic [exp_width-1:0]      exp_diff;
    logic                      a_zero;
    logic                      b_zero;
    logic                      cancel;

    // Registered payload
    logic                      large_sign;
    logic                      small_sign;
    logic                      result_sign;
    logic [exp_width-1:0]      exp_r;
    logic [full_mnt_width-1:0] large_mnt;
    logic [full_mnt_width-1:0] small_mnt;
    logic [full_mnt_width:0]   sum_mnt;
    logic                      bypass;
    float_word_t               bypass_word;

    // One pass of the normalizer
    logic [exp_width-1:0]      norm_exp;
    logic [full_mnt_width:0]   norm_mnt;
    float_word_t               packed_word;

    // Twelve left shifts at most, leading one ends at the carry position
    function automatic void shift_up_12(
        inout logic [exp_width-1:0]    exp_v,
        inout logic [full_mnt_width:0] mnt_v
    );
        for (int i = 0; i < 12; i++)
        begin
            if (!mnt_v[full_mnt_width])
            begin
                mnt_v = mnt_v << 1;
                exp_v = exp_v - 1'b1;
            end
        end
    endfunction

    ////////////////////
    // Operand ordering
    ////////////////////

    always_comb
    begin
        // Compare magnitudes as exponent then mantissa
        a_is_larger = {op.operand_a.fields.exponent, op.operand_a.fields.mantissa} >=
                      {op.operand_b.fields.exponent, op.operand_b.fields.mantissa};
        large_w     = a_is_larger ? op.operand_a : op.operand_b;
        small_w     = a_is_larger ? op.operand_b : op.operand_a;
        exp_diff    = large_w.fields.exponent - small_w.fields.exponent;

        a_zero = {op.operand_a.fields.exponent, op.operand_a.fields.mantissa} == '0;
        b_zero = {op.operand_b.fields.exponent, op.operand_b.fields.mantissa} == '0;
        // Same magnitude, opposite signs
        cancel = ({op.operand_a.fields.exponent, op.operand_a.fields.mantissa} ==
                  {op.operand_b.fields.exponent, op.operand_b.fields.mantissa}) &&
                 (op.operand_a.fields.sign != op.operand_b.fields.sign);
    end

    // Shared by both normalize stages
    always_comb
    begin
        norm_exp = exp_r;
        norm_mnt = sum_mnt;
        shift_up_12(norm_exp, norm_mnt);
    end

    // Leading one sits on the carry bit, so the fraction is one lower
    always_comb
    begin
        packed_word.fields.sign     = result_sign;
        packed_word.fields.exponent = norm_exp;
        packed_word.fields.mantissa = norm_mnt[full_mnt_width-1:1];
    end

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (i_reset)
        begin
            stage   <= 2'd0;
            op.done <= 1'b0;
        end
        else
        begin
            op.done <= 1'b0;
            if (stage == 2'd0)
            begin
                if (op.start)
                    stage <= 2'd1;
            end
            else if (stage == 2'd3)
            begin
                stage   <= 2'd0;
                op.done <= 1'b1;
            end
            else
                stage <= stage + 2'd1;
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (stage == 2'd0 && op.start)
        begin
            // Align, bits shifted out are lost
            large_mnt  <= {1'b1, large_w.fields.mantissa};
            small_mnt  <= {1'b1, small_w.fields.mantissa} >> exp_diff;
            large_sign <= large_w.fields.sign;
            small_sign <= small_w.fields.sign;
            // One extra for the carry position
            exp_r      <= large_w.fields.exponent + 1'b1;
            bypass     <= a_zero || b_zero || cancel;
            if (a_zero)
                bypass_word <= op.operand_b;
            else if (b_zero)
                bypass_word <= op.operand_a;
            else
                bypass_word <= '0;
        end

        if (stage == 2'd1)
        begin
            if (large_sign == small_sign)
                sum_mnt <= {1'b0, large_mnt} + {1'b0, small_mnt};
            else
                sum_mnt <= {1'b0, large_mnt} - {1'b0, small_mnt};
            // Common sign, or else the larger operand's
            result_sign <= large_sign;
        end

        // First twelve positions
        if (stage == 2'd2)
        begin
            exp_r   <= norm_exp;
            sum_mnt <= norm_mnt;
        end

        // Remaining positions and pack in one go
        if (stage == 2'd3)
            op.result <= bypass ? bypass_word : packed_word;
    end

endmodule

// File: src/cosine_sequencer.sv
`timescale 1ns/100ps

module cosine_sequencer
    import float_pkg::*;
    import cosine_pkg::*;
(
    input  logic                   clock,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [float_width-1:0] i_angle,
    output logic [float_width-1:0] o_cosine,
    output logic                   o_done,
    float_op_if.requester          mul_bus,
    float_op_if.requester          add_bus
);

    cosine_step_t step;
    logic         issuing;
    logic         capturing;
    logic         mul_step;
    logic         unit_done;

    // Partial terms, t1 starts out as the angle
    float_word_t  t1;
    float_word_t  t2;
    float_word_t  neg_t1;

    assign mul_step  = step inside {square, fourth, half_term, quarter_term};
    assign unit_done = mul_step ? mul_bus.done : add_bus.done;

    // One strobe per step, to whichever unit the step uses
    assign mul_bus.start = issuing && mul_step;
    assign add_bus.start = issuing && !mul_step;

    // Subtraction is an add with the sign flipped
    always_comb
    begin
        neg_t1             = t1;
        neg_t1.fields.sign = ~t1.fields.sign;
    end

    // Operands only change in the capture cycle, so they hold until done
    always_comb
    begin
        mul_bus.operand_a = t1;
        mul_bus.operand_b = t1;
        add_bus.operand_a = t1;
        add_bus.operand_b = t2;
        case (step)
            half_term:
                mul_bus.operand_b = float_half;
            quarter_term:
            begin
                mul_bus.operand_a = t2;
                mul_bus.operand_b = float_inv_24;
            end
            subtract:
            begin
                add_bus.operand_a = float_one;
                add_bus.operand_b = neg_t1;
            end
            default: ;
        endcase
    end

    ////////////////////
    // Step control
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (i_reset)
        begin
            step      <= idle;
            issuing   <= 1'b0;
            capturing <= 1'b0;
            o_done    <= 1'b0;
            o_cosine  <= '0;
        end
        else
        begin
            o_done  <= 1'b0;
            issuing <= 1'b0;
            if (step == idle)
            begin
                // Start is only seen here
                if (i_start)
                begin
                    step    <= square;
                    issuing <= 1'b1;
                end
            end
            else if (capturing)
            begin
                capturing <= 1'b0;
                issuing   <= (step != sum);
                case (step)
                    square:       step <= fourth;
                    fourth:       step <= half_term;
                    half_term:    step <= quarter_term;
                    quarter_term: step <= subtract;
                    subtract:     step <= sum;
                    default:
                    begin
                        o_cosine <= add_bus.result.raw;
                        o_done   <= 1'b1;
                        step     <= idle;
                    end
                endcase
            end
            else if (unit_done)
                capturing <= 1'b1;
        end
    end

    ////////////////////
    // Partial terms
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (step == idle && i_start)
            t1 <= i_angle;
        else if (capturing)
        begin
            case (step)
                square:       t1 <= mul_bus.result;
                fourth:       t2 <= mul_bus.result;
                half_term:    t1 <= mul_bus.result;
                quarter_term: t2 <= mul_bus.result;
                subtract:     t1 <= add_bus.result;
                default: ;
            endcase
        end
    end

endmodule

// File: src/cosine_top.sv
`timescale 1ns/100ps

module cosine_top
    import float_pkg::*;
(
    input  logic                   clock,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic [float_width-1:0] i_angle,
    output logic [float_width-1:0] o_cosine,
    output logic                   o_done
);

    // One bus per arithmetic unit
    float_op_if mul_bus ();
    float_op_if add_bus ();

    // Walks the series and owns both buses
    cosine_sequencer sequencer_inst (
        .clock    (clock),
        .i_reset  (i_reset),
        .i_start  (i_start),
        .i_angle  (i_angle),
        .o_cosine (o_cosine),
        .o_done   (o_done),
        .mul_bus  (mul_bus),
        .add_bus  (add_bus)
    );

    float_multiplier multiplier_inst (
        .clock   (clock),
        .i_reset (i_reset),
        .op      (mul_bus)
    );

    float_adder adder_inst (
        .clock   (clock),
        .i_reset (i_reset),
        .op      (add_bus)
    );

endmodule

// File: tb/cosine_top_tb.sv
`timescale 1ns/100ps

module cosine_top_tb;

    localparam int max_tests       = 64;
    // Longest wait for o_done after a start, 37 expected
    localparam int done_wait_limit = 60;
    // Cycles watched after a result for a stray o_done
    localparam int quiet_window    = 40;
    localparam int busy_delay      = 10;
    // Reset edges straddle the cycle where the aborted run would raise o_done
    localparam int reset_delay     = 34;
    localparam logic [31:0] busy_angle = 32'h3FC0_0000;

    logic        clock;
    logic        i_reset;
    logic        i_start;
    logic [31:0] i_angle;
    logic [31:0] o_cosine;
    logic        o_done;

    // Test table from the data file
    logic [31:0] test_kind   [max_tests];
    logic [31:0] test_angle  [max_tests];
    logic [31:0] test_result [max_tests];

    int num_tests    = 0;
    int pass_count   = 0;
    int fail_count   = 0;
    int check_errors = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;
    int done_total   = 0;

    cosine_top cosine_top_inst (
        .clock    (clock),
        .i_reset  (i_reset),
        .i_start  (i_start),
        .i_angle  (i_angle),
        .o_cosine (o_cosine),
        .o_done   (o_done)
    );

    always #10 clock = ~clock;

    ////////////////////
    // Run limit and monitor
    ////////////////////

    always @(posedge clock)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Every o_done pulse, gaps included
    always @(negedge clock)
        if (o_done === 1'b1)
            done_total = done_total + 1;

    ////////////////////
    // Helpers
    ////////////////////

    // Inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic pulse_start(input logic [31:0] angle);
        i_angle = angle;
        i_start = 1'b1;
        next_cycle();
        i_start = 1'b0;
    endtask

    task automatic wait_for_done(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < done_wait_limit)
        begin
            next_cycle();
            waited++;
            if (o_done === 1'b1)
                seen = 1'b1;
        end
    endtask

    // Lines that fail to scan, comments too, are skipped
    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] kind;
        logic [31:0] angle;
        logic [31:0] result;
        fd = $fopen("tb/cosine_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file tb/cosine_stimulus.txt");
            check_errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && num_tests < max_tests)
            begin
                n = $sscanf(line, "%h %h %h", kind, angle, result);
                if (n == 3)
                begin
                    test_kind[num_tests]   = kind;
                    test_angle[num_tests]  = angle;
                    test_result[num_tests] = result;
                    num_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int idx);
        bit          seen;
        bit          ok;
        int          extra;
        logic [31:0] kind;
        logic [31:0] want;
        kind  = test_kind[idx];
        want  = test_result[idx];
        ok    = 1'b1;
        extra = 0;

        // Kind 2, reset lands just before the run would finish
        if (kind == 2)
        begin
            pulse_start(test_angle[idx]);
            repeat (reset_delay) next_cycle();
            i_reset = 1'b1;
            repeat (3)
            begin
                next_cycle();
                if (o_done !== 1'b0)
                begin
                    $display("** Error: test %0d o_done expected %h, got %h",
                             idx, 1'b0, o_done);
                    ok = 1'b0;
                end
            end
            i_reset = 1'b0;
            if (o_cosine !== 32'h0)
            begin
                $display("** Error: test %0d o_cosine expected %08h, got %08h",
                         idx, 32'h0, o_cosine);
                ok = 1'b0;
            end
        end

        pulse_start(test_angle[idx]);
        // Kind 1, a second start that must be ignored
        if (kind == 1)
        begin
            repeat (busy_delay) next_cycle();
            pulse_start(busy_angle);
        end

        wait_for_done(seen);
        if (!seen)
        begin
            $display("Test %0d: o_done did not arrive within %0d cycles", idx, done_wait_limit);
            ok = 1'b0;
        end
        else if (o_cosine !== want)
        begin
            $display("** Error: test %0d o_cosine expected %08h, got %08h", idx, want, o_cosine);
            ok = 1'b0;
        end

        // Result must hold and no second o_done may follow
        if (kind == 1 && seen)
        begin
            repeat (quiet_window)
            begin
                next_cycle();
                if (o_done === 1'b1)
                    extra++;
                if (o_cosine !== want && ok)
                begin
                    $display("** Error: test %0d o_cosine expected %08h, got %08h",
                             idx, want, o_cosine);
                    ok = 1'b0;
                end
            end
            if (extra != 0)
            begin
                $display("Test %0d: start while busy caused %0d extra o_done pulses", idx, extra);
                ok = 1'b0;
            end
        end

        if (ok)
            pass_count++;
        else
            fail_count++;
        $display("Test %0d kind %0d angle %08h -> %08h %s",
                 idx, kind, test_angle[idx], want, ok ? "ok" : "failed");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        int gap;
        int seed_value;
        clock   = 1'b0;
        i_reset = 1'b1;
        i_start = 1'b0;
        i_angle = 32'h0;
        seed_value = $urandom(32'h404c_35be);

        load_tests();
        cycle_limit = num_tests * 50 + 100;

        // Reset held for three edges
        repeat (3) next_cycle();
        i_reset = 1'b0;
        if (o_done !== 1'b0)
        begin
            $display("** Error: after reset o_done expected %h, got %h", 1'b0, o_done);
            check_errors++;
        end
        if (o_cosine !== 32'h0)
        begin
            $display("** Error: after reset o_cosine expected %08h, got %08h",
                     32'h0, o_cosine);
            check_errors++;
        end

        for (int i = 0; i < num_tests; i++)
        begin
            // Idle gap of 0 to 7 cycles
            gap = $urandom % 8;
            repeat (gap) next_cycle();
            run_test(i);
        end

        // Let the monitor see the last pulse
        next_cycle();
        if (done_total != num_tests)
        begin
            $display("Saw %0d o_done pulses in total, %0d expected", done_total, num_tests);
            check_errors++;
        end
        if (num_tests == 0)
        begin
            $display("No tests were read from the stimulus file");
            check_errors++;
        end

        $display("Tests passed: %0d, failed: %0d, other errors: %0d",
                 pass_count, fail_count, check_errors);
        if (fail_count == 0 && check_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tb/cosine_stimulus.txt
// kind (0 plain, 1 extra start while busy, 2 reset mid-run then restart)
// angle word, expected cosine word, all hex
0 00000000 3F800000
0 3F000000 3F60AAAA
0 3F800000 3F0AAAAA
0 3E800000 3F780AAA
0 BF000000 3F60AAAA
0 BF800000 3F0AAAAA
0 40000000 BEAAAAAC
0 3FC00000 3DB00000
0 BFC00000 3DB00000
1 3E800000 3F780AAA
1 40000000 BEAAAAAC
2 3F800000 3F0AAAAA
0 00000000 3F800000

// File: cosine_top.f
src/float_pkg.sv
src/cosine_pkg.sv
src/float_op_if.sv
src/float_multiplier.sv
src/float_adder.sv
src/cosine_sequencer.sv
src/cosine_top.sv
tb/cosine_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cosine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f cosine_top.f \
    --top-module cosine_top_tb \
    -o cosine_sim

./obj_dir/cosine_sim > sim.log
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi
